//--- rtl/fp_format_pkg.sv
package fp_format_pkg;

    // ==================================================
    // binary32 field widths
    // ==================================================

    localparam int EXP_W_DEFAULT  = 8;  // biased exponent bits.
    localparam int FRAC_W_DEFAULT = 23; // stored fraction, hidden bit excluded.

    localparam int WORD_W_DEFAULT = 1 + EXP_W_DEFAULT + FRAC_W_DEFAULT;

    // ==================================================
    // derived encodings
    // ==================================================

    localparam int BIAS_DEFAULT = (1 << (EXP_W_DEFAULT - 1)) - 1; // 127.

    // sign 0, exponent all ones, quiet bit set.
    localparam logic [WORD_W_DEFAULT-1:0] QNAN_DEFAULT = 32'h7FC0_0000;

endpackage

//--- rtl/fmul_pkg.sv
package fmul_pkg;

    // ==================================================
    // operand classes from the unpack stage
    // ==================================================

    typedef enum logic [1:0] {
        CLS_ZERO   = 2'd0, // zero or subnormal.
        CLS_NORMAL = 2'd1,
        CLS_INF    = 2'd2,
        CLS_NAN    = 2'd3
    } op_class_t;

    // special result codes, core to round/pack.
    localparam logic [1:0] SPC_NONE = 2'd0;
    localparam logic [1:0] SPC_ZERO = 2'd1;
    localparam logic [1:0] SPC_INF  = 2'd2;
    localparam logic [1:0] SPC_NAN  = 2'd3;

    // unpack, core, round/pack.
    localparam int FMUL_LATENCY = 3;

endpackage

//--- rtl/fp_unpack.sv
`timescale 1ns/1ps

module fp_unpack #(
    parameter int EXP_W  = fp_format_pkg::EXP_W_DEFAULT,
    parameter int FRAC_W = fp_format_pkg::FRAC_W_DEFAULT
) (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  logic                      valid_i,
    input  logic [EXP_W+FRAC_W:0]     a_i,
    input  logic [EXP_W+FRAC_W:0]     b_i,
    output logic                      valid_o,
    output logic                      sign_a_o,
    output logic                      sign_b_o,
    output logic [EXP_W-1:0]          exp_a_o,
    output logic [EXP_W-1:0]          exp_b_o,
    output logic [FRAC_W:0]           sig_a_o,
    output logic [FRAC_W:0]           sig_b_o,
    output fmul_pkg::op_class_t       class_a_o,
    output fmul_pkg::op_class_t       class_b_o
);

    localparam int WORD_W = 1 + EXP_W + FRAC_W;

    function automatic fmul_pkg::op_class_t classify(
        input logic [EXP_W-1:0]  exp_f,
        input logic [FRAC_W-1:0] frac_f
    );
        fmul_pkg::op_class_t cls;
        if (exp_f == '0) begin
            cls = fmul_pkg::CLS_ZERO; // subnormals flushed here.
        end else if (exp_f == '1) begin
            cls = (frac_f == '0) ? fmul_pkg::CLS_INF : fmul_pkg::CLS_NAN;
        end else begin
            cls = fmul_pkg::CLS_NORMAL;
        end
        return cls;
    endfunction

    logic [EXP_W-1:0]  exp_a, exp_b;
    logic [FRAC_W-1:0] frac_a, frac_b;

    assign exp_a  = a_i[WORD_W-2 -: EXP_W];
    assign exp_b  = b_i[WORD_W-2 -: EXP_W];
    assign frac_a = a_i[FRAC_W-1:0];
    assign frac_b = b_i[FRAC_W-1:0];

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            sign_a_o  <= a_i[WORD_W-1];
            sign_b_o  <= b_i[WORD_W-1];
            exp_a_o   <= exp_a;
            exp_b_o   <= exp_b;
            sig_a_o   <= {1'b1, frac_a}; // hidden bit.
            sig_b_o   <= {1'b1, frac_b};
            class_a_o <= classify(exp_a, frac_a);
            class_b_o <= classify(exp_b, frac_b);
        end
    end

endmodule

//--- rtl/fmul_core.sv
`timescale 1ns/1ps

module fmul_core #(
    parameter int EXP_W  = fp_format_pkg::EXP_W_DEFAULT,
    parameter int FRAC_W = fp_format_pkg::FRAC_W_DEFAULT
) (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  logic                        valid_i,
    input  logic                        sign_a_i,
    input  logic                        sign_b_i,
    input  logic [EXP_W-1:0]            exp_a_i,
    input  logic [EXP_W-1:0]            exp_b_i,
    input  logic [FRAC_W:0]             sig_a_i,
    input  logic [FRAC_W:0]             sig_b_i,
    input  fmul_pkg::op_class_t         class_a_i,
    input  fmul_pkg::op_class_t         class_b_i,
    output logic                        valid_o,
    output logic                        sign_o,
    output logic signed [EXP_W+1:0]     exp_sum_o,
    output logic [2*FRAC_W+1:0]         prod_o,
    output logic [1:0]                  special_o
);

    localparam logic signed [EXP_W+1:0] BIAS = (EXP_W+2)'((1 << (EXP_W - 1)) - 1);

    logic signed [EXP_W+1:0] exp_sum_d;
    logic [2*FRAC_W+1:0]     prod_d;
    logic                    any_nan, any_inf, any_zero;
    logic [1:0]              special_d;

    // two guard bits keep overflow and underflow visible.
    assign exp_sum_d = $signed({2'b00, exp_a_i}) + $signed({2'b00, exp_b_i}) - BIAS;

    assign prod_d = sig_a_i * sig_b_i;

    assign any_nan  = (class_a_i == fmul_pkg::CLS_NAN)  || (class_b_i == fmul_pkg::CLS_NAN);
    assign any_inf  = (class_a_i == fmul_pkg::CLS_INF)  || (class_b_i == fmul_pkg::CLS_INF);
    assign any_zero = (class_a_i == fmul_pkg::CLS_ZERO) || (class_b_i == fmul_pkg::CLS_ZERO);

    always_comb begin
        if (any_nan || (any_inf && any_zero)) begin
            special_d = fmul_pkg::SPC_NAN; // inf * 0 is invalid.
        end else if (any_inf) begin
            special_d = fmul_pkg::SPC_INF;
        end else if (any_zero) begin
            special_d = fmul_pkg::SPC_ZERO;
        end else begin
            special_d = fmul_pkg::SPC_NONE;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            sign_o    <= sign_a_i ^ sign_b_i;
            exp_sum_o <= exp_sum_d;
            prod_o    <= prod_d;
            special_o <= special_d;
        end
    end

    // the classes from unpack must always resolve to a code.
    assert property (@(posedge clk_i) disable iff (reset_i)
        valid_o |-> !$isunknown(special_o));

endmodule

//--- rtl/fp_round_pack.sv
`timescale 1ns/1ps

module fp_round_pack #(
    parameter int EXP_W  = fp_format_pkg::EXP_W_DEFAULT,
    parameter int FRAC_W = fp_format_pkg::FRAC_W_DEFAULT
) (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  logic                        valid_i,
    input  logic                        sign_i,
    input  logic signed [EXP_W+1:0]     exp_sum_i,
    input  logic [2*FRAC_W+1:0]         prod_i,
    input  logic [1:0]                  special_i,
    output logic                        valid_o,
    output logic [EXP_W+FRAC_W:0]       result_o
);

    localparam int WORD_W = 1 + EXP_W + FRAC_W;
    localparam int PROD_W = 2 * (FRAC_W + 1);

    localparam logic signed [EXP_W+1:0] EXP_MAX = (EXP_W+2)'((1 << EXP_W) - 1);
    localparam logic signed [EXP_W+1:0] ONE     = (EXP_W+2)'(1);

    localparam logic [WORD_W-1:0] QNAN = {1'b0, {EXP_W{1'b1}}, 1'b1, {(FRAC_W-1){1'b0}}};

    // ==================================================
    // normalize and round
    // ==================================================

    logic                    prod_top;
    logic [FRAC_W-1:0]       frac_kept;
    logic                    round_bit;
    logic [FRAC_W-1:0]       frac_rnd;
    logic                    rnd_carry;
    logic signed [EXP_W+1:0] exp_norm;
    logic signed [EXP_W+1:0] exp_fin;
    logic [WORD_W-1:0]       norm_word;
    logic [WORD_W-1:0]       result_d;

    // product of two 1.x values lies in [1, 4).
    assign prod_top = prod_i[PROD_W-1];

    always_comb begin
        if (prod_top) begin
            frac_kept = prod_i[PROD_W-2 -: FRAC_W];
            round_bit = prod_i[PROD_W-2-FRAC_W];
            exp_norm  = exp_sum_i + ONE;
        end else begin
            frac_kept = prod_i[PROD_W-3 -: FRAC_W];
            round_bit = prod_i[PROD_W-3-FRAC_W];
            exp_norm  = exp_sum_i;
        end
    end

    // ties go away from zero.
    assign {rnd_carry, frac_rnd} = {1'b0, frac_kept} + (FRAC_W+1)'(round_bit);

    assign exp_fin = rnd_carry ? exp_norm + ONE : exp_norm; // fraction wraps to 0.

    // ==================================================
    // range check and specials
    // ==================================================

    always_comb begin
        if (exp_fin >= EXP_MAX) begin
            norm_word = {sign_i, {EXP_W{1'b1}}, {FRAC_W{1'b0}}}; // overflow.
        end else if (exp_fin <= 0) begin
            norm_word = {sign_i, {(EXP_W+FRAC_W){1'b0}}}; // flush to zero.
        end else begin
            norm_word = {sign_i, exp_fin[EXP_W-1:0], frac_rnd};
        end
    end

    always_comb begin
        case (special_i)
            fmul_pkg::SPC_NAN:  result_d = QNAN;
            fmul_pkg::SPC_INF:  result_d = {sign_i, {EXP_W{1'b1}}, {FRAC_W{1'b0}}};
            fmul_pkg::SPC_ZERO: result_d = {sign_i, {(EXP_W+FRAC_W){1'b0}}};
            default:            result_d = norm_word;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_o  <= 1'b0;
            result_o <= '0;
        end else begin
            valid_o <= valid_i;
            if (valid_i) begin
                result_o <= result_d; // held until next item.
            end
        end
    end

    // finite operands must never produce a nan pattern.
    assert property (@(posedge clk_i) disable iff (reset_i)
        (valid_i && special_i == fmul_pkg::SPC_NONE) |=>
            (result_o[WORD_W-2 -: EXP_W] != '1) || (result_o[FRAC_W-1:0] == '0));

endmodule

//--- rtl/fp_mul.sv
`timescale 1ns/1ps

module fp_mul #(
    parameter int EXP_W  = fp_format_pkg::EXP_W_DEFAULT,
    parameter int FRAC_W = fp_format_pkg::FRAC_W_DEFAULT
) (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  logic                    valid_i,
    input  logic [EXP_W+FRAC_W:0]   a_i,
    input  logic [EXP_W+FRAC_W:0]   b_i,
    output logic                    valid_o,
    output logic [EXP_W+FRAC_W:0]   result_o
);

    // unpack to core.
    logic                unp_valid;
    logic                unp_sign_a, unp_sign_b;
    logic [EXP_W-1:0]    unp_exp_a, unp_exp_b;
    logic [FRAC_W:0]     unp_sig_a, unp_sig_b;
    fmul_pkg::op_class_t unp_class_a, unp_class_b;

    // core to round/pack.
    logic                    core_valid;
    logic                    core_sign;
    logic signed [EXP_W+1:0] core_exp_sum;
    logic [2*FRAC_W+1:0]     core_prod;
    logic [1:0]              core_special;

    fp_unpack #(
        .EXP_W  (EXP_W),
        .FRAC_W (FRAC_W)
    ) fp_unpack_inst (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .valid_i   (valid_i),
        .a_i       (a_i),
        .b_i       (b_i),
        .valid_o   (unp_valid),
        .sign_a_o  (unp_sign_a),
        .sign_b_o  (unp_sign_b),
        .exp_a_o   (unp_exp_a),
        .exp_b_o   (unp_exp_b),
        .sig_a_o   (unp_sig_a),
        .sig_b_o   (unp_sig_b),
        .class_a_o (unp_class_a),
        .class_b_o (unp_class_b)
    );

    fmul_core #(
        .EXP_W  (EXP_W),
        .FRAC_W (FRAC_W)
    ) fmul_core_inst (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .valid_i   (unp_valid),
        .sign_a_i  (unp_sign_a),
        .sign_b_i  (unp_sign_b),
        .exp_a_i   (unp_exp_a),
        .exp_b_i   (unp_exp_b),
        .sig_a_i   (unp_sig_a),
        .sig_b_i   (unp_sig_b),
        .class_a_i (unp_class_a),
        .class_b_i (unp_class_b),
        .valid_o   (core_valid),
        .sign_o    (core_sign),
        .exp_sum_o (core_exp_sum),
        .prod_o    (core_prod),
        .special_o (core_special)
    );

    fp_round_pack #(
        .EXP_W  (EXP_W),
        .FRAC_W (FRAC_W)
    ) fp_round_pack_inst (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .valid_i   (core_valid),
        .sign_i    (core_sign),
        .exp_sum_i (core_exp_sum),
        .prod_i    (core_prod),
        .special_i (core_special),
        .valid_o   (valid_o),
        .result_o  (result_o)
    );

    // every input strobe leaves exactly after the pipeline depth.
    assert property (@(posedge clk_i) disable iff (reset_i)
        valid_o == $past(valid_i, fmul_pkg::FMUL_LATENCY));

endmodule

//--- testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 2
) (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        reset_o <= 1'b0; // released on an edge.
    end

endmodule

//--- testbench/tb_fp_mul.sv
`timescale 1ns/1ps

module tb_fp_mul;

    localparam int CLK_PERIOD_NS = 20;
    localparam int RANDOM_PAIRS  = 24;
    localparam int NUM_VECTORS   = 24 + RANDOM_PAIRS; // directed plus random.
    localparam int NUM_BURSTS    = 7;
    localparam int DRAIN_CYCLES  = 8;
    localparam int TIMEOUT_NS    =
        (NUM_VECTORS + NUM_BURSTS * (DRAIN_CYCLES + 1) + 10) * CLK_PERIOD_NS + 500;

    logic        clk, reset;
    logic        valid_i, valid_o;
    logic [31:0] a_i, b_i, result_o;

    logic [31:0] expected_q[$];
    int          issue_q[$];
    int          cycle_cnt;
    int          value_errors;
    int          protocol_errors;
    logic [31:0] exp_word;
    int          issued;
    logic [15:0] lfsr_state;

    tb_clock_gen #(
        .PERIOD_NS    (CLK_PERIOD_NS),
        .RESET_CYCLES (2)
    ) tb_clock_gen_inst (
        .clk_o   (clk),
        .reset_o (reset)
    );

    fp_mul #(
        .EXP_W  (fp_format_pkg::EXP_W_DEFAULT),
        .FRAC_W (fp_format_pkg::FRAC_W_DEFAULT)
    ) fp_mul_inst (
        .clk_i    (clk),
        .reset_i  (reset),
        .valid_i  (valid_i),
        .a_i      (a_i),
        .b_i      (b_i),
        .valid_o  (valid_o),
        .result_o (result_o)
    );

    // ==================================================
    // reference model and random source
    // ==================================================

    function automatic logic [31:0] ref_mul(input logic [31:0] a, input logic [31:0] b);
        int              ea, eb, e;
        longint unsigned p, frac, rnd;
        logic            s, any_nan, any_inf, any_zero;
        s        = a[31] ^ b[31];
        ea       = a[30:23];
        eb       = b[30:23];
        any_nan  = (ea == 255 && a[22:0] != 0) || (eb == 255 && b[22:0] != 0);
        any_inf  = (ea == 255 && a[22:0] == 0) || (eb == 255 && b[22:0] == 0);
        any_zero = (ea == 0) || (eb == 0); // subnormals count as zero.
        if (any_nan || (any_inf && any_zero))
            return 32'h7FC0_0000;
        if (any_inf)
            return {s, 8'hFF, 23'd0};
        if (any_zero)
            return {s, 31'd0};
        p = longint'({1'b1, a[22:0]}) * longint'({1'b1, b[22:0]});
        e = ea + eb - 127;
        if (p >= (64'd1 << 47)) begin
            frac = (p >> 24) & 64'h7F_FFFF;
            rnd  = (p >> 23) & 64'd1;
            e    = e + 1;
        end else begin
            frac = (p >> 23) & 64'h7F_FFFF;
            rnd  = (p >> 22) & 64'd1;
        end
        frac = frac + rnd;
        if (frac == (64'd1 << 23)) begin
            frac = 0;
            e    = e + 1;
        end
        if (e >= 255)
            return {s, 8'hFF, 23'd0};
        if (e <= 0)
            return {s, 31'd0};
        return {s, e[7:0], frac[22:0]};
    endfunction

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0])
            n = n ^ 16'hB400;
        return n;
    endfunction

    task automatic random_word(output logic [31:0] w);
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w = {w[30:0], lfsr_state[0]};
        end
    endtask

    // ==================================================
    // stimulus
    // ==================================================

    task automatic drive_pair(input logic [31:0] a, input logic [31:0] b);
        @(posedge clk);
        valid_i <= 1'b1;
        a_i     <= a;
        b_i     <= b;
        expected_q.push_back(ref_mul(a, b));
    endtask

    task automatic finish_burst();
        int n;
        n = 0;
        @(posedge clk);
        valid_i <= 1'b0;
        while (expected_q.size() != 0 && n < DRAIN_CYCLES) begin
            @(negedge clk);
            n++;
        end
        assert (expected_q.size() == 0) else begin
            protocol_errors++;
            $display("%0d results never came out on valid_o", expected_q.size());
            expected_q.delete();
            issue_q.delete();
        end
    endtask

    task automatic test_reset_idle();
        repeat (4) begin
            @(negedge clk);
            assert (valid_o === 1'b0) else begin
                value_errors++;
                $display("Error at %0d ns: valid_o expected 0, actual %b", $time, valid_o);
            end
            assert (result_o === 32'd0) else begin
                value_errors++;
                $display("Error at %0d ns: result_o expected 0, actual %h", $time, result_o);
            end
        end
    endtask

    task automatic test_latency();
        drive_pair(32'h3FC0_0000, 32'h4000_0000);
        finish_burst();
        drive_pair(32'h4040_0000, 32'h3F00_0000);
        finish_burst();
    endtask

    task automatic test_exact();
        drive_pair(32'h3FC0_0000, 32'h4000_0000); // 1.5 * 2.0.
        drive_pair(32'hC040_0000, 32'h3F00_0000); // -3.0 * 0.5.
        drive_pair(32'h4040_0000, 32'hC080_0000);
        finish_burst();
    endtask

    task automatic test_rounding();
        drive_pair(32'h3F80_0003, 32'h3FC0_0000); // tie on an even fraction, rounds up.
        drive_pair(32'h3F80_0001, 32'h3F80_0001); // round bit clear.
        drive_pair(32'h3F80_0001, 32'h3FFF_FFFE); // carry lifts to 2.0.
        finish_burst();
    endtask

    task automatic test_specials();
        drive_pair(32'h0000_0000, 32'h40A0_0000);
        drive_pair(32'h8000_0000, 32'h40A0_0000);
        drive_pair(32'h0000_0000, 32'hC000_0000);
        drive_pair(32'h7F80_0000, 32'h4000_0000);
        drive_pair(32'hFF80_0000, 32'h4000_0000);
        drive_pair(32'h7F80_0000, 32'hFF80_0000);
        drive_pair(32'h7FC0_0001, 32'h3F80_0000);
        drive_pair(32'hFFFF_FFFF, 32'h0000_0000);
        drive_pair(32'h7F80_0000, 32'h0000_0000); // inf * 0.
        drive_pair(32'hFF80_0000, 32'h8000_0000);
        drive_pair(32'h0000_0001, 32'h3F80_0000); // subnormal in.
        drive_pair(32'h807F_FFFF, 32'h4000_0000);
        finish_burst();
    endtask

    task automatic test_range();
        drive_pair(32'h7F00_0000, 32'h7F00_0000);
        drive_pair(32'hFF00_0000, 32'h7F00_0000);
        drive_pair(32'h0080_0000, 32'h0080_0000);
        drive_pair(32'h8080_0000, 32'h3F00_0000); // tiny result flushed.
        finish_burst();
    endtask

    task automatic test_random();
        logic [31:0] a, b;
        for (int i = 0; i < RANDOM_PAIRS; i++) begin
            random_word(a);
            random_word(b);
            if (i % 2 == 0) begin
                a[30] = ~a[29]; // keeps the exponent near the bias.
                b[30] = ~b[29];
            end
            drive_pair(a, b);
        end
        finish_burst();
    endtask

    // ==================================================
    // monitor, run control
    // ==================================================

    always @(posedge clk) begin
        cycle_cnt++;
        if (!reset) begin
            if (valid_i)
                issue_q.push_back(cycle_cnt);
            if (valid_o) begin
                if (expected_q.size() == 0) begin
                    protocol_errors++;
                    $display("valid_o at %0d ns with no input waiting for it", $time);
                end else begin
                    exp_word = expected_q.pop_front();
                    issued   = issue_q.pop_front();
                    assert (result_o === exp_word) else begin
                        value_errors++;
                        $display("Error at %0d ns: result_o expected %h, actual %h",
                                 $time, exp_word, result_o);
                    end
                    // both strobes are seen on the edge that samples them.
                    assert (cycle_cnt - issued == fmul_pkg::FMUL_LATENCY) else begin
                        protocol_errors++;
                        $display("valid_o came %0d cycles after valid_i",
                                 cycle_cnt - issued);
                    end
                end
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns, the run did not finish", TIMEOUT_NS);
        $display("errors: %0d wrong values, %0d protocol", value_errors, protocol_errors);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        valid_i         <= 1'b0;
        a_i             <= '0;
        b_i             <= '0;
        cycle_cnt       = 0;
        value_errors    = 0;
        protocol_errors = 0;
        lfsr_state      = 16'd12083;
        @(posedge clk);
        while (reset)
            @(posedge clk);
        test_reset_idle();
        test_latency();
        test_exact();
        test_rounding();
        test_specials();
        test_range();
        test_random();
        $display("errors: %0d wrong values, %0d protocol", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

//--- project.f
rtl/fp_format_pkg.sv
rtl/fmul_pkg.sv
rtl/fp_unpack.sv
rtl/fmul_core.sv
rtl/fp_round_pack.sv
rtl/fp_mul.sv
testbench/tb_clock_gen.sv
testbench/tb_fp_mul.sv

//--- Bender.yml
package:
  name: fp_mul

sources:
  - files:
      - rtl/fp_format_pkg.sv
      - rtl/fmul_pkg.sv
      - rtl/fp_unpack.sv
      - rtl/fmul_core.sv
      - rtl/fp_round_pack.sv
      - rtl/fp_mul.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_fp_mul.sv
